// File: hdl/bpu.sv
// Gshare branch predictor with global history, combined with BTB lookup
module bpu import fetch_pkg::*; #(
  parameter int HLEN     = 4,
  parameter int BTB_BITS = 4
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,
  input  logic [XLEN-1:0] pc_i,

  // Resolution from branch unit
  input  logic            res_valid_i,
  input  logic [XLEN-1:0] res_pc_i,
  input  logic            res_taken_i,
  input  logic [XLEN-1:0] res_target_i,
  input  logic            res_mispredict_i,

  output logic            pred_taken_o,
  output logic [XLEN-1:0] pred_target_o
);

  localparam int PHT_SIZE = 2**HLEN;

  logic [HLEN-1:0] history_q;
  counter_e        pht_q [PHT_SIZE];
  logic [HLEN-1:0] pred_idx;
  logic [HLEN-1:0] res_idx;
  counter_e        pred_cnt;
  logic            btb_hit;
  logic [XLEN-1:0] btb_target;

  // Saturating step toward the outcome
  function automatic counter_e next_count(counter_e cnt, logic taken);
    counter_e nxt;
    case (cnt)
      STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      default:   nxt = taken ? STRONG_T : WEAK_T;
    endcase
    return nxt;
  endfunction

  // -----------------------------------------------
  // Gshare table
  // -----------------------------------------------
  // Word PC bits hashed with global history
  assign pred_idx = pc_i[HLEN+1:2] ^ history_q;
  assign res_idx  = res_pc_i[HLEN+1:2] ^ history_q;
  assign pred_cnt = pht_q[pred_idx];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht_q[i] <= WEAK_NT;
      end
    end else if (res_valid_i) begin
      pht_q[res_idx] <= next_count(pht_q[res_idx], res_taken_i);
    end
  end

  // Flush clears only the history and counters keep training
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      history_q <= '0;
    end else if (res_valid_i) begin
      history_q <= (history_q << 1) | HLEN'(res_taken_i);
    end
  end

  // -----------------------------------------------
  // Target lookup
  // -----------------------------------------------
  btb #(
    .BTB_BITS (BTB_BITS)
  ) u_btb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .pc_i         (pc_i),
    .upd_valid_i  (res_valid_i & res_taken_i),
    .upd_pc_i     (res_pc_i),
    .upd_target_i (res_target_i),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // Taken needs both a known target and a taken-leaning counter
  assign pred_taken_o  = btb_hit && (pred_cnt == WEAK_T || pred_cnt == STRONG_T);
  assign pred_target_o = btb_target;

endmodule

// File: hdl/btb.sv
// Direct-mapped branch target buffer holding a tag and target per entry
module btb import fetch_pkg::*; #(
  parameter int BTB_BITS = 4
) (
  input  logic            clk_i,
  input  logic            reset_i,

  // Lookup
  input  logic [XLEN-1:0] pc_i,

  // Update from taken resolutions
  input  logic            upd_valid_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic [XLEN-1:0] upd_target_i,

  output logic            hit_o,
  output logic [XLEN-1:0] target_o
);

  localparam int ENTRIES = 2**BTB_BITS;
  // Upper PC bits above index and byte offset
  localparam int TAG_W   = XLEN - BTB_BITS - 2;

  logic [ENTRIES-1:0]  valid_q;
  logic [TAG_W-1:0]    tag_q    [ENTRIES];
  logic [XLEN-1:0]     target_q [ENTRIES];
  logic [BTB_BITS-1:0] rd_idx;
  logic [BTB_BITS-1:0] wr_idx;
  logic [TAG_W-1:0]    rd_tag;
  logic [TAG_W-1:0]    wr_tag;

  assign rd_idx = pc_i[BTB_BITS+1:2];
  assign rd_tag = pc_i[XLEN-1:BTB_BITS+2];
  assign wr_idx = upd_pc_i[BTB_BITS+1:2];
  assign wr_tag = upd_pc_i[XLEN-1:BTB_BITS+2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Last taken branch owns the slot
  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_target_i;
    end
  end

  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];

endmodule

// File: hdl/fetch_pkg.sv
// Shared widths and encodings for the RV32 instruction-fetch stage
package fetch_pkg;

  // -----------------------------------------------
  // Widths
  // -----------------------------------------------
  // Address width
  localparam int XLEN = 32;

  // Instruction width without compressed support
  localparam int ILEN = 32;

  // -----------------------------------------------
  // Fetch exceptions
  // -----------------------------------------------
  // Values follow the RISC-V mcause encoding
  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGNED   = 4'd0,
    EXC_INSTR_ACCESS_FAULT = 4'd1
  } except_code_e;

  // -----------------------------------------------
  // Branch predictor counters
  // -----------------------------------------------
  // Two-bit saturating counter
  // MSB set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } counter_e;

endpackage

// File: hdl/fetch_stage.sv
// Instruction-fetch stage top level joining cache interface, fetch unit and predictor
module fetch_stage import fetch_pkg::*; #(
  parameter int HLEN     = 4,
  parameter int BTB_BITS = 4
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,

  // From/to PC generator
  input  logic [XLEN-1:0] pc_i,
  input  logic            pc_valid_i,
  output logic            fetch_ready_o,

  // To/from instruction cache
  output logic [XLEN-1:0] addr_o,
  output logic            addr_valid_o,
  input  logic            addr_ready_i,
  input  logic [ILEN-1:0] data_i,
  input  logic            data_err_i,
  input  logic            data_valid_i,
  output logic            data_ready_o,

  // To/from decode
  input  logic            issue_ready_i,
  output logic            issue_valid_o,
  output logic [ILEN-1:0] instruction_o,
  output logic            except_o,
  output except_code_e    except_code_o,

  // Prediction for the incoming PC
  output logic            pred_taken_o,
  output logic [XLEN-1:0] pred_target_o,

  // From branch unit
  input  logic            res_valid_i,
  input  logic [XLEN-1:0] res_pc_i,
  input  logic            res_taken_i,
  input  logic [XLEN-1:0] res_target_i,
  input  logic            res_mispredict_i
);

  logic            read_req;
  logic            read_done;
  logic [ILEN-1:0] cache_instr;
  logic            cache_err;
  logic            bpu_flush;

  // -----------------------------------------------
  // Cache interface
  // -----------------------------------------------
  icache_ifc u_icache_ifc (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .pc_i          (pc_i),
    .read_req_i    (read_req),
    .cache_instr_o (cache_instr),
    .cache_err_o   (cache_err),
    .read_done_o   (read_done),
    .addr_o        (addr_o),
    .addr_valid_o  (addr_valid_o),
    .addr_ready_i  (addr_ready_i),
    .data_i        (data_i),
    .data_err_i    (data_err_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o)
  );

  // -----------------------------------------------
  // Fetch unit
  // -----------------------------------------------
  ifu u_ifu (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .pc_i          (pc_i),
    .pc_valid_i    (pc_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .cache_instr_i (cache_instr),
    .cache_err_i   (cache_err),
    .read_done_i   (read_done),
    .read_req_o    (read_req),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instruction_o (instruction_o),
    .except_o      (except_o),
    .except_code_o (except_code_o)
  );

  // -----------------------------------------------
  // Branch predictor
  // -----------------------------------------------
  // History survives a mispredict flush since the resolution retrains it
  assign bpu_flush = flush_i & ~res_mispredict_i;

  bpu #(
    .HLEN     (HLEN),
    .BTB_BITS (BTB_BITS)
  ) u_bpu (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (bpu_flush),
    .pc_i             (pc_i),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_taken_i      (res_taken_i),
    .res_target_i     (res_target_i),
    .res_mispredict_i (res_mispredict_i),
    .pred_taken_o     (pred_taken_o),
    .pred_target_o    (pred_target_o)
  );

endmodule

// File: hdl/icache_ifc.sv
// I-cache request and response controller for one outstanding access
module icache_ifc import fetch_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,

  // From/to fetch unit
  input  logic [XLEN-1:0] pc_i,
  input  logic            read_req_i,
  output logic [ILEN-1:0] cache_instr_o,
  output logic            cache_err_o,
  output logic            read_done_o,

  // Cache address channel
  output logic [XLEN-1:0] addr_o,
  output logic            addr_valid_o,
  input  logic            addr_ready_i,

  // Cache data channel
  input  logic [ILEN-1:0] data_i,
  input  logic            data_err_i,
  input  logic            data_valid_i,
  output logic            data_ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    SEND_ADDR,
    WAIT_DATA,
    DRAIN
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic [XLEN-1:0] addr_q;
  logic [ILEN-1:0] instr_q;
  logic            err_q;
  logic            pend_q;
  logic            done_q;
  logic            addr_hs;
  logic            data_hs;

  assign addr_hs = addr_valid_o & addr_ready_i;
  assign data_hs = data_valid_i & data_ready_o;

  // -----------------------------------------------
  // Next state
  // -----------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (read_req_i) begin
          state_d = SEND_ADDR;
        end
      end
      SEND_ADDR: begin
        // Address already taken by the cache so a response is still owed
        if (addr_hs) begin
          state_d = flush_i ? DRAIN : WAIT_DATA;
        end else if (flush_i) begin
          state_d = IDLE;
        end
      end
      WAIT_DATA: begin
        if (data_hs) begin
          state_d = IDLE;
        end else if (flush_i) begin
          state_d = DRAIN;
        end
      end
      default: begin
        // Swallow the stale answer then serve a request queued meanwhile
        if (data_hs) begin
          state_d = ((pend_q | read_req_i) & ~flush_i) ? SEND_ADDR : IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request arriving while a stale response drains
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      pend_q <= 1'b0;
    end else if (state_q == DRAIN) begin
      pend_q <= data_hs ? 1'b0 : (pend_q | read_req_i);
    end
  end

  // -----------------------------------------------
  // Address and response capture
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (read_req_i) begin
      addr_q <= pc_i;
    end
    if (state_q == WAIT_DATA && data_hs) begin
      instr_q <= data_i;
      err_q   <= data_err_i;
    end
  end

  // Done pulse only for a live, unflushed access
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= (state_q == WAIT_DATA) & data_hs & ~flush_i;
    end
  end

  assign addr_o        = addr_q;
  assign addr_valid_o  = (state_q == SEND_ADDR);
  assign data_ready_o  = (state_q == WAIT_DATA) || (state_q == DRAIN);
  assign cache_instr_o = instr_q;
  assign cache_err_o   = err_q;
  assign read_done_o   = done_q;

  // Address must not move while the cache stalls it
  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    addr_valid_o && !addr_ready_i |=> $stable(addr_o));

endmodule

// File: hdl/ifu.sv
// Fetch unit with PC acceptance, alignment check and issue register toward decode
module ifu import fetch_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,

  // From/to PC generator
  input  logic [XLEN-1:0] pc_i,
  input  logic            pc_valid_i,
  output logic            fetch_ready_o,

  // From/to cache interface
  input  logic [ILEN-1:0] cache_instr_i,
  input  logic            cache_err_i,
  input  logic            read_done_i,
  output logic            read_req_o,

  // From/to decode
  input  logic            issue_ready_i,
  output logic            issue_valid_o,
  output logic [ILEN-1:0] instruction_o,
  output logic            except_o,
  output except_code_e    except_code_o
);

  typedef enum logic [1:0] {
    READY,
    FETCHING,
    HOLDING
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic            accept;
  logic            misaligned;
  logic            resp_in;
  logic [ILEN-1:0] instr_q;
  logic            except_q;
  except_code_e    code_q;

  // No new PC during a flush cycle
  assign fetch_ready_o = (state_q == READY) & ~flush_i;
  assign accept        = fetch_ready_o & pc_valid_i;
  assign misaligned    = (pc_i[1:0] != 2'b00);
  assign resp_in       = (state_q == FETCHING) & read_done_i;

  // Misaligned PC never reaches the cache
  assign read_req_o = accept & ~misaligned;

  // -----------------------------------------------
  // Control FSM
  // -----------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      READY: begin
        if (accept) begin
          state_d = misaligned ? HOLDING : FETCHING;
        end
      end
      FETCHING: begin
        if (flush_i) begin
          state_d = READY;
        end else if (read_done_i) begin
          state_d = HOLDING;
        end
      end
      default: begin
        if (flush_i || issue_ready_i) begin
          state_d = READY;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= READY;
    end else begin
      state_q <= state_d;
    end
  end

  // -----------------------------------------------
  // Issue register
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      except_q <= 1'b0;
    end else if (accept && misaligned) begin
      except_q <= 1'b1;
    end else if (resp_in) begin
      except_q <= cache_err_i;
    end
  end

  // Instruction zeroed on any exception
  // Code only meaningful with except_o set
  always_ff @(posedge clk_i) begin
    if (accept && misaligned) begin
      instr_q <= '0;
      code_q  <= EXC_INSTR_MISALIGNED;
    end else if (resp_in) begin
      instr_q <= cache_err_i ? '0 : cache_instr_i;
      code_q  <= EXC_INSTR_ACCESS_FAULT;
    end
  end

  assign issue_valid_o = (state_q == HOLDING);
  assign instruction_o = instr_q;
  assign except_o      = except_q;
  assign except_code_o = code_q;

  // Decode back-pressure holds the whole issue bundle
  a_issue_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_valid_o && !issue_ready_i && !flush_i |=>
      issue_valid_o && $stable(instruction_o) && $stable(except_o) &&
      $stable(except_code_o));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_fetch_stage -f sources.f -o tb_fetch_stage > build.log 2>&1 \
  && ./obj_dir/tb_fetch_stage > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// File: sources.f
hdl/fetch_pkg.sv
hdl/icache_ifc.sv
hdl/ifu.sv
hdl/btb.sv
hdl/bpu.sv
hdl/fetch_stage.sv
test/tb_fetch_stage.sv

// File: test/fetch_patterns.txt
# kind pc taken target mispredict exp_pred_taken exp_pred_target exp_code (f = none)
# F fetch, R resolve, X fetch flushed while awaiting data; counters start at WEAK_NT
F 00001000 0 00000000 0 0 00000000 f
F 00000102 0 00000000 0 0 00000000 0
F 80000040 0 00000000 0 0 00000000 1
F 00000110 0 00000000 0 0 00000000 f
R 00000110 1 00000200 0 0 00000000 f
X 00003000 0 00000000 0 0 00000000 f
R 00000110 1 00000200 0 0 00000000 f
X 00003100 0 00000000 0 0 00000000 f
F 00000110 0 00000000 0 1 00000200 f
F 00000150 0 00000000 0 0 00000000 f
F 00003000 0 00000000 0 0 00000000 f
R 00000120 1 00000400 1 0 00000000 f
X 00003200 0 00000000 1 0 00000000 f
F 00000120 0 00000000 0 0 00000000 f
X 00003300 0 00000000 0 0 00000000 f
F 00000120 0 00000000 0 1 00000400 f
R 00000110 0 00000000 0 0 00000000 f
F 00000110 0 00000000 0 1 00000200 f
R 00000110 0 00000000 0 0 00000000 f
F 00000110 0 00000000 0 0 00000000 f
F 80001000 0 00000000 0 0 00000000 1
F 00000203 0 00000000 0 0 00000000 0
F 00000130 0 00000000 0 0 00000000 f

// File: test/tb_fetch_stage.sv
// Fetch stage testbench with cache and decode models, pattern-driven checks and report
module tb_fetch_stage import fetch_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int              CLK_HALF        = 4;
  localparam int              RESET_CYCLES    = 4;
  localparam logic [31:0]     SEED            = 32'h772d_7023;
  localparam logic [ILEN-1:0] INSTR_XOR       = 32'h1357_9bdf;
  localparam int              CYCLES_PER_PAT  = 12;
  localparam int              TIMEOUT_MARGIN  = 50;
  // Pattern code for a fetch without exception
  localparam logic [3:0]      NO_EXCEPT       = 4'hf;

  // -----------------------------------------------
  // DUT signals
  // -----------------------------------------------
  logic            clk_i         = 1'b0;
  logic            reset_i;
  logic            flush_i;
  logic [XLEN-1:0] pc_i;
  logic            pc_valid_i;
  logic            fetch_ready_o;
  logic [XLEN-1:0] addr_o;
  logic            addr_valid_o;
  logic            addr_ready_i  = 1'b0;
  logic [ILEN-1:0] data_i        = '0;
  logic            data_err_i    = 1'b0;
  logic            data_valid_i  = 1'b0;
  logic            data_ready_o;
  logic            issue_ready_i = 1'b0;
  logic            issue_valid_o;
  logic [ILEN-1:0] instruction_o;
  logic            except_o;
  except_code_e    except_code_o;
  logic            pred_taken_o;
  logic [XLEN-1:0] pred_target_o;
  logic            res_valid_i;
  logic [XLEN-1:0] res_pc_i;
  logic            res_taken_i;
  logic [XLEN-1:0] res_target_i;
  logic            res_mispredict_i;

  // Pattern columns with one entry per line
  byte             pat_kind       [$];
  logic [XLEN-1:0] pat_pc         [$];
  logic            pat_taken      [$];
  logic [XLEN-1:0] pat_target     [$];
  logic            pat_mis        [$];
  logic            pat_exp_taken  [$];
  logic [XLEN-1:0] pat_exp_target [$];
  logic [3:0]      pat_exp_code   [$];

  int              errors         = 0;
  int              checks         = 0;
  int              stall_errors   = 0;
  int              stall_checks   = 0;
  int              addr_hs_count  = 0;
  int unsigned     timeout_cycles = 0;
  int unsigned     cycle_count    = 0;

  // Cache model state
  logic            resp_pending   = 1'b0;
  logic [XLEN-1:0] resp_addr      = '0;
  logic            next_valid;
  int              data_delay     = 0;
  int              ready_delay    = 0;

  // Back-pressure monitor state
  logic            held_valid     = 1'b0;
  logic [ILEN-1:0] held_instr;
  logic            held_except;
  except_code_e    held_code;

  fetch_stage #(
    .HLEN     (4),
    .BTB_BITS (4)
  ) u_dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .pc_i             (pc_i),
    .pc_valid_i       (pc_valid_i),
    .fetch_ready_o    (fetch_ready_o),
    .addr_o           (addr_o),
    .addr_valid_o     (addr_valid_o),
    .addr_ready_i     (addr_ready_i),
    .data_i           (data_i),
    .data_err_i       (data_err_i),
    .data_valid_i     (data_valid_i),
    .data_ready_o     (data_ready_o),
    .issue_ready_i    (issue_ready_i),
    .issue_valid_o    (issue_valid_o),
    .instruction_o    (instruction_o),
    .except_o         (except_o),
    .except_code_o    (except_code_o),
    .pred_taken_o     (pred_taken_o),
    .pred_target_o    (pred_target_o),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_taken_i      (res_taken_i),
    .res_target_i     (res_target_i),
    .res_mispredict_i (res_mispredict_i)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // Random decode stalls in roughly one cycle of four
  always @(posedge clk_i) begin
    issue_ready_i <= (($urandom % 4) != 0);
  end

  // -----------------------------------------------
  // Cache model
  // -----------------------------------------------
  // Decide at the falling edge, drive at the rising edge
  always begin : cache_model
    @(negedge clk_i);
    next_valid = data_valid_i;
    if (data_valid_i && data_ready_o) begin
      next_valid = 1'b0;
    end else if (resp_pending) begin
      if (data_delay == 0) begin
        next_valid   = 1'b1;
        resp_pending = 1'b0;
      end else begin
        data_delay--;
      end
    end
    if (addr_valid_o && addr_ready_i) begin
      resp_addr    = addr_o;
      resp_pending = 1'b1;
      data_delay   = $urandom % 4;
      ready_delay  = $urandom % 4;
      addr_hs_count++;
    end else if (addr_valid_o && ready_delay != 0) begin
      ready_delay--;
    end
    @(posedge clk_i);
    addr_ready_i <= (ready_delay == 0);
    data_valid_i <= next_valid;
    data_i       <= resp_addr ^ INSTR_XOR;
    // Upper half of the address space faults
    data_err_i   <= resp_addr[31];
  end

  // Issue bundle must hold while decode stalls
  always @(negedge clk_i) begin
    if (held_valid) begin
      stall_checks++;
      assert (issue_valid_o && instruction_o == held_instr && except_o == held_except &&
              except_code_o == held_code) else begin
        stall_errors++;
        $display("issue outputs changed while decode was stalling them");
      end
    end
    if (!reset_i && issue_valid_o && !issue_ready_i) begin
      stall_checks++;
      assert (!fetch_ready_o) else begin
        stall_errors++;
        $display("fetch_ready_o was high while decode stalled the issue outputs");
      end
    end
    held_valid  = !reset_i && issue_valid_o && !issue_ready_i && !flush_i;
    held_instr  = instruction_o;
    held_except = except_o;
    held_code   = except_code_o;
  end

  function automatic int total_errors();
    return errors + stall_errors;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic load_patterns();
    int              fd;
    int              fields;
    string           line;
    byte             kind;
    logic [XLEN-1:0] pc;
    logic            taken;
    logic [XLEN-1:0] target;
    logic            mis;
    logic            exp_taken;
    logic [XLEN-1:0] exp_target;
    logic [3:0]      code;
    fd = $fopen("test/fetch_patterns.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Comment and blank lines fail to parse all eight columns
        fields = $sscanf(line, "%c %h %h %h %h %h %h %h", kind, pc, taken, target, mis,
                         exp_taken, exp_target, code);
        if (fields == 8) begin
          pat_kind.push_back(kind);
          pat_pc.push_back(pc);
          pat_taken.push_back(taken);
          pat_target.push_back(target);
          pat_mis.push_back(mis);
          pat_exp_taken.push_back(exp_taken);
          pat_exp_target.push_back(exp_target);
          pat_exp_code.push_back(code);
        end
      end
      $fclose(fd);
    end
  endtask

  // -----------------------------------------------
  // Pattern actions
  // -----------------------------------------------
  // Offer a PC, check the same-cycle prediction, return on the accept edge
  task automatic present_pc(input logic [XLEN-1:0] pc, input logic exp_taken,
                            input logic [XLEN-1:0] exp_target);
    @(posedge clk_i);
    pc_i       <= pc;
    pc_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
    end while (!fetch_ready_o);
    check_value("pred_taken_o", 32'(pred_taken_o), 32'(exp_taken));
    if (exp_taken) begin
      check_value("pred_target_o", pred_target_o, exp_target);
    end
    @(posedge clk_i);
    pc_valid_i <= 1'b0;
  endtask

  task automatic fetch_and_check(input int i);
    int              hs_before;
    logic            exp_except;
    logic [ILEN-1:0] exp_instr;
    hs_before  = addr_hs_count;
    exp_except = (pat_exp_code[i] != NO_EXCEPT);
    exp_instr  = exp_except ? '0 : (pat_pc[i] ^ INSTR_XOR);
    present_pc(pat_pc[i], pat_exp_taken[i], pat_exp_target[i]);
    do begin
      @(negedge clk_i);
    end while (!(issue_valid_o && issue_ready_i));
    check_value("instruction_o", instruction_o, exp_instr);
    check_value("except_o", 32'(except_o), 32'(exp_except));
    if (exp_except) begin
      check_value("except_code_o", 32'(except_code_o), 32'(pat_exp_code[i]));
    end
    if (pat_pc[i][1:0] != 2'b00) begin
      checks++;
      assert (addr_hs_count == hs_before) else begin
        errors++;
        $display("misaligned PC %h was sent to the cache", pat_pc[i]);
      end
    end
    @(posedge clk_i);
  endtask

  task automatic apply_resolution(input int i);
    @(posedge clk_i);
    res_valid_i      <= 1'b1;
    res_pc_i         <= pat_pc[i];
    res_taken_i      <= pat_taken[i];
    res_target_i     <= pat_target[i];
    res_mispredict_i <= pat_mis[i];
    @(posedge clk_i);
    res_valid_i      <= 1'b0;
    res_mispredict_i <= 1'b0;
  endtask

  // Fetch flushed after the address handshake while its response is still owed
  task automatic flush_during_fetch(input int i);
    present_pc(pat_pc[i], pat_exp_taken[i], pat_exp_target[i]);
    do begin
      @(negedge clk_i);
    end while (!(addr_valid_o && addr_ready_i));
    @(posedge clk_i);
    flush_i          <= 1'b1;
    res_mispredict_i <= pat_mis[i];
    @(posedge clk_i);
    flush_i          <= 1'b0;
    res_mispredict_i <= 1'b0;
    do begin
      @(negedge clk_i);
      checks++;
      assert (!issue_valid_o) else begin
        errors++;
        $display("flushed fetch of %h still reached decode", pat_pc[i]);
      end
    end while (data_ready_o);
  endtask

  initial begin : watchdog
    while (timeout_cycles == 0 || cycle_count < timeout_cycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    int n;
    int err_before;
    reset_i          = 1'b1;
    flush_i          = 1'b0;
    pc_i             = '0;
    pc_valid_i       = 1'b0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_taken_i      = 1'b0;
    res_target_i     = '0;
    res_mispredict_i = 1'b0;
    void'($urandom(SEED));
    load_patterns();
    n = pat_kind.size();
    timeout_cycles = n * CYCLES_PER_PAT + TIMEOUT_MARGIN;
    if (n == 0) begin
      errors++;
      $display("no patterns could be read from test/fetch_patterns.txt");
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int i = 0; i < n; i++) begin
      err_before = total_errors();
      case (pat_kind[i])
        "F": fetch_and_check(i);
        "R": apply_resolution(i);
        "X": flush_during_fetch(i);
        default: begin
          errors++;
          $display("pattern %0d has an unknown kind", i);
        end
      endcase
      $display("test %0d %c pc=%h: %s", i, pat_kind[i], pat_pc[i],
               (total_errors() == err_before) ? "ok" : "FAILED");
    end

    $display("Summary: %0d tests, %0d checks, %0d errors", n, checks + stall_checks,
             total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
